//--- source/uart_config.svh
`ifndef UART_CONFIG_SVH
`define UART_CONFIG_SVH

//////////////////////////////
// line timing
//////////////////////////////

// clk_tx cycles per bit on txd
// 16 keeps simulation short, 868 gives 115200 baud from 100 MHz
`define UART_CLKS_PER_BIT 16

//////////////////////////////
// buffering
//////////////////////////////

// frame FIFO entries, power of two
`define UART_FIFO_DEPTH 8

`endif

//--- source/uart_pkg.sv
package uart_pkg;

    //////////////////////////////
    // line format
    //////////////////////////////

    // parity selection, sampled with each host write
    typedef enum logic [1:0] {
        parity_none = 2'd0, // no parity bit on the line
        parity_even = 2'd1, // ones in data + parity is even
        parity_odd  = 2'd2  // ones in data + parity is odd
    } parity_mode_t;

    //////////////////////////////
    // frame carried by the FIFO
    //////////////////////////////

    // one byte plus everything the serializer needs to frame it,
    // so the format is fixed at write time
    typedef struct packed {
        logic [7:0] data;       // payload byte, sent lsb first
        logic       parity_en;  // send a parity bit after data
        logic       parity_bit; // precomputed parity value
        logic       stop2;      // two stop bits instead of one
    } tx_frame_t;

endpackage

//--- source/tx_frame_builder.sv
`timescale 1ns/1ps

module tx_frame_builder import uart_pkg::*; (
    input  logic         clk_tx,
    input  logic         rst,
    input  logic         wr_strobe,    // one cycle, data valid alongside
    input  logic [7:0]   wr_data,
    input  parity_mode_t parity_mode,  // static level
    input  logic         stop2,        // static level
    output logic         frame_strobe, // one cycle after wr_strobe
    output tx_frame_t    frame
);

    //////////////////////////////
    // parity
    //////////////////////////////

    // value of the parity bit for a given byte and mode
    // none returns 0, the bit is never sent then
    function automatic logic calc_parity(input logic [7:0] data, input parity_mode_t mode);
        logic ones_odd;
        ones_odd = ^data; // high when data holds an odd count of ones
        case (mode)
            parity_even: calc_parity = ones_odd;  // make total even
            parity_odd:  calc_parity = ~ones_odd; // make total odd
            default:     calc_parity = 1'b0;
        endcase
    endfunction

    //////////////////////////////
    // strobe
    //////////////////////////////

    always_ff @(posedge clk_tx) begin
        if (rst) begin
            frame_strobe <= 1'b0;
        end else begin
            frame_strobe <= wr_strobe; // 1 cycle latency
        end
    end

    //////////////////////////////
    // frame register
    //////////////////////////////

    // format latched per byte, so later config changes
    // only touch later bytes
    always_ff @(posedge clk_tx) begin
        if (wr_strobe) begin
            frame.data       <= wr_data;
            frame.parity_en  <= (parity_mode != parity_none);
            frame.parity_bit <= calc_parity(wr_data, parity_mode);
            frame.stop2      <= stop2;
        end
    end

endmodule

//--- source/tx_fifo.sv
`timescale 1ns/1ps

module tx_fifo import uart_pkg::*; #(
    parameter type payload_t = tx_frame_t,
    parameter int  DEPTH     = 8 // power of two
) (
    input  logic     clk_tx,
    input  logic     rst,
    input  logic     push,
    input  payload_t push_data,
    input  logic     pop,      // caller guarantees not empty
    output payload_t head,     // entry at the read pointer
    output logic     empty,
    output logic     overflow  // sticky until rst
);

    localparam int ADDR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    payload_t            mem [DEPTH];
    logic [ADDR_W-1:0]   wr_ptr;
    logic [ADDR_W-1:0]   rd_ptr;
    logic [ADDR_W:0]     count;  // one extra bit to hold DEPTH
    logic                full;
    logic                push_ok;

    assign full    = (count == (ADDR_W+1)'(DEPTH));
    assign empty   = (count == '0);
    assign push_ok = push && !full; // full push is simply lost
    assign head    = mem[rd_ptr];   // no output register

    //////////////////////////////
    // storage
    //////////////////////////////

    always_ff @(posedge clk_tx) begin
        if (push_ok) begin
            mem[wr_ptr] <= push_data;
        end
    end

    //////////////////////////////
    // pointers and occupancy
    //////////////////////////////

    always_ff @(posedge clk_tx) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push_ok) begin
                wr_ptr <= wr_ptr + 1'b1; // wraps, DEPTH is 2^n
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push_ok, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count; // both or neither
            endcase
        end
    end

    //////////////////////////////
    // overflow flag
    //////////////////////////////

    always_ff @(posedge clk_tx) begin
        if (rst) begin
            overflow <= 1'b0;
        end else if (push && full) begin
            overflow <= 1'b1; // stays set
        end
    end

endmodule

//--- source/uart_tx.sv
`timescale 1ns/1ps
`include "uart_config.svh"

module uart_tx import uart_pkg::*; (
    input  logic      clk_tx,
    input  logic      rst,
    input  logic      empty,
    input  tx_frame_t head,
    output logic      pop,   // one cycle, frame taken
    output logic      txd,   // idle high
    output logic      busy
);

    localparam int CNT_W = ($clog2(`UART_CLKS_PER_BIT) > 0) ? $clog2(`UART_CLKS_PER_BIT) : 1;
    localparam logic [CNT_W-1:0] CNT_RELOAD = CNT_W'(`UART_CLKS_PER_BIT - 1);

    typedef enum logic [2:0] {
        st_idle,
        st_start,
        st_data,
        st_parity,
        st_stop
    } state_t;

    state_t           state;
    logic [CNT_W-1:0] baud_cnt;  // counts down to 0 per bit
    logic [2:0]       bit_idx;   // data bit on the line
    logic             stop_idx;  // second stop bit in progress
    logic [7:0]       shift_reg; // lsb is on the line
    logic             par_en;
    logic             par_bit;
    logic             stop2_q;
    logic             bit_done;
    logic             last_stop;

    assign bit_done  = (baud_cnt == '0);
    // final tick of the final stop bit
    assign last_stop = (state == st_stop) && bit_done && (!stop2_q || stop_idx);

    // take a frame when idle, or right at the end of the current one
    assign pop  = !empty && ((state == st_idle) || last_stop);
    assign busy = (state != st_idle) || pop;

    //////////////////////////////
    // control fsm
    //////////////////////////////

    always_ff @(posedge clk_tx) begin
        if (rst) begin
            state    <= st_idle;
            baud_cnt <= CNT_RELOAD;
            bit_idx  <= '0;
            stop_idx <= 1'b0;
        end else if (pop) begin
            state    <= st_start; // start bit from next cycle
            baud_cnt <= CNT_RELOAD;
            bit_idx  <= '0;
            stop_idx <= 1'b0;
        end else begin
            if (state == st_idle || bit_done) begin
                baud_cnt <= CNT_RELOAD;
            end else begin
                baud_cnt <= baud_cnt - 1'b1;
            end
            case (state)
                st_start: if (bit_done) state <= st_data;
                st_data: begin
                    if (bit_done) begin
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx == 3'd7) begin // msb just finished
                            state <= par_en ? st_parity : st_stop;
                        end
                    end
                end
                st_parity: if (bit_done) state <= st_stop;
                st_stop: begin
                    if (bit_done) begin
                        if (stop2_q && !stop_idx) begin
                            stop_idx <= 1'b1; // one more stop bit
                        end else begin
                            state <= st_idle; // nothing queued
                        end
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    //////////////////////////////
    // frame datapath
    //////////////////////////////

    always_ff @(posedge clk_tx) begin
        if (pop) begin
            shift_reg <= head.data;
            par_en    <= head.parity_en;
            par_bit   <= head.parity_bit;
            stop2_q   <= head.stop2;
        end else if (state == st_data && bit_done) begin
            shift_reg <= {1'b0, shift_reg[7:1]}; // next bit down to lsb
        end
    end

    //////////////////////////////
    // line output
    //////////////////////////////

    always_comb begin
        case (state)
            st_start:  txd = 1'b0;
            st_data:   txd = shift_reg[0];
            st_parity: txd = par_bit;
            default:   txd = 1'b1; // idle and stop
        endcase
    end

endmodule

//--- source/uart_tx_top.sv
`timescale 1ns/1ps
`include "uart_config.svh"

module uart_tx_top import uart_pkg::*; (
    input  logic         clk_tx,
    input  logic         rst,
    input  logic         wr_strobe,   // no ready, write is fire and forget
    input  logic [7:0]   wr_data,
    input  parity_mode_t parity_mode,
    input  logic         stop2,
    output logic         txd,
    output logic         busy,
    output logic         overflow     // write lost on full FIFO
);

    logic      frame_strobe;
    tx_frame_t frame;
    logic      pop;
    logic      empty;
    tx_frame_t head;

    //////////////////////////////
    // producer
    //////////////////////////////

    tx_frame_builder i_builder (
        .clk_tx       (clk_tx),
        .rst          (rst),
        .wr_strobe    (wr_strobe),
        .wr_data      (wr_data),
        .parity_mode  (parity_mode),
        .stop2        (stop2),
        .frame_strobe (frame_strobe),
        .frame        (frame)
    );

    //////////////////////////////
    // frame buffer
    //////////////////////////////

    tx_fifo #(
        .payload_t (tx_frame_t),
        .DEPTH     (`UART_FIFO_DEPTH)
    ) i_fifo (
        .clk_tx    (clk_tx),
        .rst       (rst),
        .push      (frame_strobe),
        .push_data (frame),
        .pop       (pop),
        .head      (head),
        .empty     (empty),
        .overflow  (overflow)
    );

    //////////////////////////////
    // serializer
    //////////////////////////////

    uart_tx i_tx (
        .clk_tx (clk_tx),
        .rst    (rst),
        .empty  (empty),
        .head   (head),
        .pop    (pop),
        .txd    (txd),
        .busy   (busy)
    );

endmodule

//--- tb/tb_uart_tx_top.sv
`timescale 1ns/1ps
`include "uart_config.svh"

module tb_uart_tx_top import uart_pkg::*; ();

    localparam int CLKS  = `UART_CLKS_PER_BIT;
    localparam int DEPTH = `UART_FIFO_DEPTH;
    // frames sent over all tests at up to 12 bits each
    localparam int NUM_FRAMES     = 1 + 4 + 2 + 20 + (DEPTH + 1) + 4;
    localparam int TIMEOUT_CYCLES = NUM_FRAMES * 12 * CLKS + 200;

    logic         clk_tx;
    logic         rst;
    logic         wr_strobe;
    logic [7:0]   wr_data;
    parity_mode_t parity_mode;
    logic         stop2;
    logic         txd;
    logic         busy;
    logic         overflow;

    tx_frame_t    model_q[$];               // frames expected on txd, in order
    int           cycle_cnt  = 0;
    logic [31:0]  rng_state  = 32'he1371e6c;

    uart_tx_top i_dut (
        .clk_tx      (clk_tx),
        .rst         (rst),
        .wr_strobe   (wr_strobe),
        .wr_data     (wr_data),
        .parity_mode (parity_mode),
        .stop2       (stop2),
        .txd         (txd),
        .busy        (busy),
        .overflow    (overflow)
    );

    initial begin
        clk_tx = 1'b0;
        forever #20 clk_tx = ~clk_tx;       // 40 ns period
    end

    always @(posedge clk_tx) cycle_cnt <= cycle_cnt + 1;

    initial begin
        wait (cycle_cnt >= TIMEOUT_CYCLES);
        $display("timeout: no end of test after %0d clock cycles", TIMEOUT_CYCLES);
        $display("TEST FAIL");
        $fatal(1, "simulation ran past its cycle limit");
    end

    //////////////////////////////
    // helpers
    //////////////////////////////

    task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        if (actual !== expected) begin
            $display("FAILED at %0t ns: %s, got %0h, expected %0h", $time, what, actual,
                     expected);
            $display("TEST FAIL");
            $fatal(1, "value mismatch");
        end
    endtask

    function automatic logic [31:0] next_random();
        rng_state = rng_state ^ (rng_state << 13); // xorshift32
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    function automatic parity_mode_t mode_from_index(input logic [31:0] idx);
        case (idx % 32'd3)
            32'd0:   return parity_none;
            32'd1:   return parity_even;
            default: return parity_odd;
        endcase
    endfunction

    // parity bit that makes the total count of ones even or odd
    function automatic logic expected_parity(input logic [7:0] data, input parity_mode_t mode);
        int   ones;
        int   i;
        logic ones_odd;
        ones = 0;
        for (i = 0; i < 8; i++) begin
            ones = ones + int'(data[i]);
        end
        ones_odd = ((ones % 2) == 1);
        case (mode)
            parity_even: return ones_odd;
            parity_odd:  return !ones_odd;
            default:     return 1'b0;   // never sent
        endcase
    endfunction

    // called on a falling edge so back to back calls give back to back strobes
    task automatic write_byte(input logic [7:0] data, input parity_mode_t mode,
                              input logic two_stop, input logic accept);
        tx_frame_t exp;
        wr_strobe   = 1'b1;
        wr_data     = data;
        parity_mode = mode;
        stop2       = two_stop;
        if (accept) begin               // only writes the FIFO will keep
            exp.data       = data;
            exp.parity_en  = (mode != parity_none);
            exp.parity_bit = expected_parity(data, mode);
            exp.stop2      = two_stop;
            model_q.push_back(exp);
        end
        @(negedge clk_tx);
        wr_strobe = 1'b0;
    endtask

    //////////////////////////////
    // line decoder
    //////////////////////////////

    // samples mid-bit on falling clock edges and returns in the last stop bit
    task automatic receive_frame(output int start_cyc);
        tx_frame_t  exp;
        logic [7:0] data;
        int         i;
        @(negedge txd);                 // leading edge of start bit
        @(negedge clk_tx);
        start_cyc = cycle_cnt;
        check_value(32'(model_q.size() > 0), 32'd1, "frame on txd has a queued write");
        exp = model_q.pop_front();
        repeat (CLKS / 2 - 1) @(negedge clk_tx);
        check_value(32'(txd), 32'd0, "start bit low at mid-bit");
        for (i = 0; i < 8; i++) begin
            repeat (CLKS) @(negedge clk_tx);
            data[i] = txd;              // lsb first
        end
        check_value(32'(data), 32'(exp.data), "data byte");
        if (exp.parity_en) begin
            repeat (CLKS) @(negedge clk_tx);
            check_value(32'(txd), 32'(exp.parity_bit), "parity bit");
        end
        repeat (CLKS) @(negedge clk_tx);
        check_value(32'(txd), 32'd1, "first stop bit");
        if (exp.stop2) begin
            repeat (CLKS) @(negedge clk_tx);
            check_value(32'(txd), 32'd1, "second stop bit");
        end
    endtask

    task automatic wait_idle();
        while (busy) @(negedge clk_tx);
    endtask

    task automatic expect_line_idle(input int cycles);
        repeat (cycles) begin
            @(negedge clk_tx);
            check_value(32'(busy), 32'd0, "busy low while line idle");
            check_value(32'(txd), 32'd1, "txd high while line idle");
        end
    endtask

    //////////////////////////////
    // directed tests
    //////////////////////////////

    task automatic test_single_byte();
        int s0;
        write_byte(8'hA5, parity_none, 1'b0, 1'b1);
        receive_frame(s0);
        check_value(32'(busy), 32'd1, "busy during stop bit");
        wait_idle();
        expect_line_idle(2 * CLKS);
        check_value(32'(model_q.size()), 32'd0, "all frames of single byte test seen");
    endtask

    task automatic test_parity_modes();
        int s0, s1, s2, s3;
        fork
            begin
                write_byte(8'hA7, parity_even, 1'b0, 1'b1); // 5 ones so parity bit 1
                write_byte(8'h3D, parity_odd, 1'b0, 1'b1);  // 5 ones so parity bit 0
                write_byte(8'h42, parity_none, 1'b0, 1'b1);
                write_byte(8'h99, parity_none, 1'b0, 1'b1);
            end
            begin
                receive_frame(s0);
                receive_frame(s1);
                receive_frame(s2);
                receive_frame(s3);
            end
        join
        check_value(32'(s1 - s0), 32'(11 * CLKS), "even parity frame length");
        check_value(32'(s2 - s1), 32'(11 * CLKS), "odd parity frame length");
        check_value(32'(s3 - s2), 32'(10 * CLKS), "no parity frame length");
        wait_idle();
    endtask

    task automatic test_two_stop_bits();
        int s0, s1;
        fork
            begin
                write_byte(8'h81, parity_none, 1'b1, 1'b1);
                write_byte(8'h7E, parity_none, 1'b1, 1'b1);
            end
            begin
                receive_frame(s0);
                receive_frame(s1);
            end
        join
        check_value(32'(s1 - s0), 32'(11 * CLKS), "second start after two stop bits");
        wait_idle();
    endtask

    task automatic test_random_burst();
        int s0;
        fork
            begin
                logic [31:0] r;
                int          gap;
                repeat (20) begin
                    r = next_random();
                    write_byte(r[7:0], mode_from_index(next_random()), 1'b0, 1'b1);
                    gap = 10 * CLKS + int'(next_random() % 32'(CLKS)); // FIFO stays short
                    repeat (gap) @(negedge clk_tx);
                end
            end
            repeat (20) receive_frame(s0);
        join
        check_value(32'(overflow), 32'd0, "no overflow in paced burst");
        check_value(32'(model_q.size()), 32'd0, "all burst frames seen");
        wait_idle();
    endtask

    task automatic test_overflow();
        int s0;
        int i;
        wait_idle();
        fork
            for (i = 0; i < DEPTH + 3; i++) begin
                // one in flight plus a full FIFO are kept and the rest is lost
                write_byte(8'(i + 16), parity_none, 1'b0, (i <= DEPTH));
            end
            repeat (DEPTH + 1) receive_frame(s0);
        join
        wait_idle();
        expect_line_idle(2 * CLKS);     // dropped bytes must not show up
        check_value(32'(overflow), 32'd1, "overflow set after full FIFO");
        check_value(32'(model_q.size()), 32'd0, "all accepted frames seen");
    endtask

    task automatic test_config_change();
        int s0, s1, s2, s3;
        fork
            begin
                write_byte(8'hC3, parity_even, 1'b1, 1'b1);
                while (!busy) @(negedge clk_tx);
                repeat (3) @(negedge clk_tx);
                write_byte(8'h5A, parity_odd, 1'b0, 1'b1);
                repeat (2) @(negedge clk_tx);
                write_byte(8'h0F, parity_none, 1'b1, 1'b1);
                repeat (2) @(negedge clk_tx);
                write_byte(8'hF0, parity_even, 1'b0, 1'b1);
                parity_mode = parity_odd; // later change without a strobe
                stop2       = 1'b1;
            end
            begin
                receive_frame(s0);
                receive_frame(s1);
                receive_frame(s2);
                receive_frame(s3);
            end
        join
        check_value(32'(s1 - s0), 32'(12 * CLKS), "even, two stop frame length");
        check_value(32'(s2 - s1), 32'(11 * CLKS), "odd, one stop frame length");
        check_value(32'(s3 - s2), 32'(11 * CLKS), "none, two stop frame length");
        // last frame keeps its single stop bit despite the later stop2 change
        repeat (CLKS - CLKS / 2 + 1) @(negedge clk_tx);
        check_value(32'(busy), 32'd0, "last frame ends after one stop bit");
        wait_idle();
    endtask

    //////////////////////////////
    // main sequence
    //////////////////////////////

    initial begin
        rst         = 1'b1;
        wr_strobe   = 1'b0;
        wr_data     = 8'h00;
        parity_mode = parity_none;
        stop2       = 1'b0;
        repeat (2) @(negedge clk_tx);   // two reset cycles
        rst = 1'b0;
        check_value(32'(txd), 32'd1, "txd high after reset");
        check_value(32'(busy), 32'd0, "busy low after reset");
        check_value(32'(overflow), 32'd0, "overflow low after reset");
        test_single_byte();
        test_parity_modes();
        test_two_stop_bits();
        test_random_burst();
        test_overflow();
        test_config_change();
        $display("TEST PASS");
        $finish;
    end

endmodule

//--- filelist.f
+incdir+source
source/uart_pkg.sv
source/tx_frame_builder.sv
source/tx_fifo.sv
source/uart_tx.sv
source/uart_tx_top.sv
tb/tb_uart_tx_top.sv

//--- Makefile
TOOL       ?= verilator
TOP        ?= tb_uart_tx_top
RTL_TOP    ?= uart_tx_top
FILELIST   ?= filelist.f
FLAGS      ?= --binary --timing -j 0
LINT_FLAGS ?= --lint-only --timing -Wall
OBJ_DIR    ?= obj_dir
LOG        ?= sim.log

.PHONY: all build run lint clean

# build and run, pass only when the log holds the pass line
all: run

build:
	$(TOOL) $(FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "TEST PASS" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation did not pass, see $(LOG)"; \
		exit 1; \
	fi

lint:
	$(TOOL) $(LINT_FLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
